// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module ntt_r16_tb -f flist.f

run: compile
	out="$$(./obj_dir/Vntt_r16_tb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== flist.f ====
rtl/ntt_arith_pkg.sv
rtl/ntt_bus_pkg.sv
rtl/ntt_stage_if.sv
rtl/ntt_bus_decode.sv
rtl/ntt_butterfly.sv
rtl/ntt_stage.sv
rtl/ntt_result.sv
rtl/ntt_r16_top.sv
sim/ntt_r16_assertions.sv
sim/ntt_r16_tb.sv

// ==== rtl/ntt_arith_pkg.sv ====
package ntt_arith_pkg;

    // transform size
    parameter int ntt_n = 16;

    // one butterfly stage per bit of the index
    parameter int ntt_log_n = 4;

    parameter int coef_width = 16;

    // coefficient, twiddle factor or modulus
    typedef logic [coef_width-1:0] coef_t;

    // whole data or twiddle vector of one transform
    typedef coef_t coef_vec_t [ntt_n];

endpackage

// ==== rtl/ntt_bus_decode.sv ====
`timescale 1ns/1ps

module ntt_bus_decode (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [ntt_bus_pkg::wb_addr_width-1:0] wb_adr,
    input logic [ntt_bus_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [ntt_bus_pkg::wb_data_width-1:0] wb_dat_r,
    output logic wb_ack,
    ntt_stage_if.src launch,
    input ntt_arith_pkg::coef_vec_t result,
    input logic done
);
    import ntt_arith_pkg::*;
    import ntt_bus_pkg::*;

    logic req;
    logic write_en;
    logic start_write;
    logic [1:0] region;
    logic [ntt_log_n-1:0] index;

    coef_vec_t coef_regs;
    coef_vec_t twiddle_regs;
    coef_t modulus_reg;

    assign region = wb_adr[wb_addr_width-1 -: 2];
    assign index = wb_adr[ntt_log_n-1:0];

    // ack blocks a second request while the master still holds stb
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign write_en = req && wb_we;
    assign start_write = write_en && (region == region_ctrl) &&
                         (index == ctrl_start_addr) && wb_dat_w[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            coef_regs <= '{default: '0};
            twiddle_regs <= '{default: '0};
            modulus_reg <= '0;
        end else if (write_en) begin
            case (region)
                region_coef: coef_regs[index] <= wb_dat_w[coef_width-1:0];
                region_twiddle: twiddle_regs[index] <= wb_dat_w[coef_width-1:0];
                region_ctrl: begin
                    if (index == ctrl_modulus_addr) begin
                        modulus_reg <= wb_dat_w[coef_width-1:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // snapshot so later bus writes cannot disturb a transform in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            launch.valid <= 1'b0;
            launch.data <= '{default: '0};
            launch.twiddle <= '{default: '0};
            launch.modulus <= '0;
        end else begin
            launch.valid <= start_write;
            if (start_write) begin
                launch.data <= coef_regs;
                launch.twiddle <= twiddle_regs;
                launch.modulus <= modulus_reg;
            end
        end
    end

    // address is held until ack, so read data follows it directly
    always_comb begin
        wb_dat_r = '0;
        case (region)
            region_coef: wb_dat_r[coef_width-1:0] = coef_regs[index];
            region_twiddle: wb_dat_r[coef_width-1:0] = twiddle_regs[index];
            region_result: wb_dat_r[coef_width-1:0] = result[index];
            default: begin
                if (index == ctrl_modulus_addr) begin
                    wb_dat_r[coef_width-1:0] = modulus_reg;
                end else if (index == ctrl_start_addr) begin
                    wb_dat_r[0] = done;
                end
            end
        endcase
    end

endmodule

// ==== rtl/ntt_bus_pkg.sv ====
package ntt_bus_pkg;

    parameter int wb_data_width = 32;

    // word address with the region in bits 5:4 and the element index below
    parameter int wb_addr_width = 6;

    // regions
    parameter logic [1:0] region_coef = 2'd0;
    parameter logic [1:0] region_twiddle = 2'd1;
    parameter logic [1:0] region_result = 2'd2;
    parameter logic [1:0] region_ctrl = 2'd3;

    // control registers
    parameter logic [3:0] ctrl_modulus_addr = 4'd0;
    parameter logic [3:0] ctrl_start_addr = 4'd1;

endpackage

// ==== rtl/ntt_butterfly.sv ====
`timescale 1ns/1ps

module ntt_butterfly (
    input ntt_arith_pkg::coef_t a,
    input ntt_arith_pkg::coef_t b,
    input ntt_arith_pkg::coef_t w,
    input ntt_arith_pkg::coef_t q,
    output ntt_arith_pkg::coef_t sum,
    output ntt_arith_pkg::coef_t diff
);
    import ntt_arith_pkg::*;

    logic [2*coef_width-1:0] product;
    logic [2*coef_width-1:0] reduced;
    coef_t prod_mod;
    logic [coef_width:0] sum_raw;

    // w * b mod q
    assign product = w * b;
    assign reduced = product % {{coef_width{1'b0}}, q};
    assign prod_mod = reduced[coef_width-1:0];

    // a + p can reach 2q - 2 and needs one extra bit
    assign sum_raw = {1'b0, a} + {1'b0, prod_mod};
    assign sum = (sum_raw >= {1'b0, q}) ? coef_t'(sum_raw - {1'b0, q})
                                        : sum_raw[coef_width-1:0];

    // add q back when a - p would go negative
    assign diff = (a >= prod_mod) ? coef_t'(a - prod_mod)
                                  : coef_t'(a + (q - prod_mod));

endmodule

// ==== rtl/ntt_r16_top.sv ====
`timescale 1ns/1ps

module ntt_r16_top (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [ntt_bus_pkg::wb_addr_width-1:0] wb_adr,
    input logic [ntt_bus_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [ntt_bus_pkg::wb_data_width-1:0] wb_dat_r,
    output logic wb_ack
);
    import ntt_arith_pkg::*;

    coef_vec_t result;
    logic done;

    // link 0 leaves the decoder and link ntt_log_n enters the result buffer
    ntt_stage_if stage_link [ntt_log_n + 1] ();

    ntt_bus_decode i_ntt_bus_decode (
        .clk(clk),
        .rst(rst),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .launch(stage_link[0]),
        .result(result),
        .done(done)
    );

    for (genvar s = 0; s < ntt_log_n; s++) begin : g_stage
        ntt_stage #(
            .stage_index(s)
        ) i_ntt_stage (
            .clk(clk),
            .rst(rst),
            .up(stage_link[s]),
            .down(stage_link[s + 1])
        );
    end

    ntt_result i_ntt_result (
        .clk(clk),
        .rst(rst),
        .final_stage(stage_link[ntt_log_n]),
        .launch_seen(stage_link[0].valid),
        .result(result),
        .done(done)
    );

endmodule

// ==== rtl/ntt_result.sv ====
`timescale 1ns/1ps

module ntt_result (
    input logic clk,
    input logic rst,
    ntt_stage_if.dst final_stage,
    input logic launch_seen,
    output ntt_arith_pkg::coef_vec_t result,
    output logic done
);

    // results stay in in-place order
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '{default: '0};
        end else if (final_stage.valid) begin
            result <= final_stage.data;
        end
    end

    // a completing transform beats a fresh launch in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else if (final_stage.valid) begin
            done <= 1'b1;
        end else if (launch_seen) begin
            done <= 1'b0;
        end
    end

endmodule

// ==== rtl/ntt_stage.sv ====
`timescale 1ns/1ps

module ntt_stage #(
    parameter int stage_index = 0
) (
    input logic clk,
    input logic rst,
    ntt_stage_if.dst up,
    ntt_stage_if.src down
);
    import ntt_arith_pkg::*;

    // distance between the two elements of a butterfly
    localparam int half_span = ntt_n >> (stage_index + 1);

    coef_vec_t bf_out;

    function automatic int bit_reverse(input int value);
        int reversed;
        reversed = 0;
        for (int k = 0; k < ntt_log_n; k++) begin
            reversed = (reversed << 1) | ((value >> k) & 1);
        end
        return reversed;
    endfunction

    for (genvar k = 0; k < ntt_n / 2; k++) begin : g_bfly
        localparam int group = k / half_span;
        localparam int lo = group * 2 * half_span + (k % half_span);
        localparam int hi = lo + half_span;
        // twiddles are stored bit-reversed
        localparam int tw_index = bit_reverse((1 << stage_index) + group);

        ntt_butterfly i_ntt_butterfly (
            .a(up.data[lo]),
            .b(up.data[hi]),
            .w(up.twiddle[tw_index]),
            .q(up.modulus),
            .sum(bf_out[lo]),
            .diff(bf_out[hi])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            down.valid <= 1'b0;
            down.data <= '{default: '0};
            down.twiddle <= '{default: '0};
            down.modulus <= '0;
        end else begin
            down.valid <= up.valid;
            if (up.valid) begin
                down.data <= bf_out;
                down.twiddle <= up.twiddle;
                down.modulus <= up.modulus;
            end
        end
    end

endmodule

// ==== rtl/ntt_stage_if.sv ====
`timescale 1ns/1ps

interface ntt_stage_if;
    import ntt_arith_pkg::*;

    // one cycle per transform
    logic valid;
    coef_vec_t data;

    // operands travel with their data
    coef_vec_t twiddle;
    coef_t modulus;

    modport src (
        output valid,
        output data,
        output twiddle,
        output modulus
    );

    modport dst (
        input valid,
        input data,
        input twiddle,
        input modulus
    );

endinterface

// ==== sim/ntt_r16_assertions.sv ====
`timescale 1ns/1ps

module ntt_r16_assertions (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [ntt_bus_pkg::wb_addr_width-1:0] wb_adr,
    input logic [ntt_bus_pkg::wb_data_width-1:0] wb_dat_w,
    input logic [ntt_bus_pkg::wb_data_width-1:0] wb_dat_r,
    input logic wb_ack
);
    import ntt_arith_pkg::*;
    import ntt_bus_pkg::*;

    int error_count = 0;

    logic req;
    logic start;
    logic read_ack;
    logic [1:0] region;
    logic [3:0] index;
    logic [wb_data_width-1:0] expected_rd;

    // operand mirror and a model of the five-edge pipeline
    coef_vec_t coef_m;
    coef_vec_t tw_m;
    coef_t q_m;
    logic [4:0] pipe_valid;
    coef_vec_t pipe_vec [5];
    coef_vec_t res_m;
    logic done_m;

    function automatic coef_vec_t transform(input coef_vec_t x, input coef_vec_t tw,
                                            input coef_t q);
        coef_vec_t v;
        int k;
        int rev;
        longint t;
        longint u;
        v = x;
        k = 1;
        for (int span = ntt_n / 2; span >= 1; span = span / 2) begin
            for (int first = 0; first < ntt_n; first += 2 * span) begin
                rev = 0;
                for (int b = 0; b < ntt_log_n; b++) begin
                    rev = (rev << 1) | ((k >> b) & 1);
                end
                k++;
                for (int j = first; j < first + span; j++) begin
                    t = (longint'(tw[rev]) * longint'(v[j + span])) % longint'(q);
                    u = longint'(v[j]);
                    v[j] = coef_t'((u + t) % longint'(q));
                    v[j + span] = coef_t'((u - t + longint'(q)) % longint'(q));
                end
            end
        end
        return v;
    endfunction

    assign req = wb_cyc && wb_stb && !wb_ack;
    assign region = wb_adr[5:4];
    assign index = wb_adr[3:0];
    assign start = req && wb_we && region == region_ctrl && index == ctrl_start_addr &&
                   wb_dat_w[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            coef_m <= '{default: '0};
            tw_m <= '{default: '0};
            q_m <= '0;
            read_ack <= 1'b0;
            pipe_valid <= '0;
            pipe_vec <= '{default: '{default: '0}};
            res_m <= '{default: '0};
            done_m <= 1'b0;
        end else begin
            if (req && wb_we) begin
                if (region == region_coef) coef_m[index] <= wb_dat_w[15:0];
                if (region == region_twiddle) tw_m[index] <= wb_dat_w[15:0];
                if (region == region_ctrl && index == ctrl_modulus_addr) q_m <= wb_dat_w[15:0];
            end
            // the ack cycle that answers a read request
            read_ack <= req && !wb_we;
            pipe_valid <= {pipe_valid[3:0], start};
            if (start) begin
                pipe_vec[0] <= transform(coef_m, tw_m, q_m);
            end
            for (int s = 1; s < 5; s++) begin
                pipe_vec[s] <= pipe_vec[s - 1];
            end
            if (pipe_valid[4]) begin
                res_m <= pipe_vec[4];
                done_m <= 1'b1;
            end else if (pipe_valid[0]) begin
                done_m <= 1'b0;
            end
        end
    end

    always_comb begin
        expected_rd = '0;
        case (region)
            region_coef: expected_rd[15:0] = coef_m[index];
            region_twiddle: expected_rd[15:0] = tw_m[index];
            region_result: expected_rd[15:0] = res_m[index];
            default: begin
                if (index == ctrl_modulus_addr) expected_rd[15:0] = q_m;
                else if (index == ctrl_start_addr) expected_rd[0] = done_m;
            end
        endcase
    end

    ack_low_in_reset: assert property (@(posedge clk) rst |-> !wb_ack)
        else begin
            error_count++;
            $error("wb_ack high during reset");
        end
    ack_follows_req: assert property (@(posedge clk) disable iff (rst) req |=> wb_ack)
        else begin
            error_count++;
            $error("wb_ack missing after a request");
        end
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        !(wb_cyc && wb_stb) |=> !wb_ack)
        else begin
            error_count++;
            $error("wb_ack raised without a request");
        end
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            error_count++;
            $error("wb_ack held for more than one cycle");
        end

    operand_readback: assert property (@(posedge clk) disable iff (rst)
        (read_ack && region != region_result && !(region == region_ctrl &&
        index == ctrl_start_addr)) |-> wb_dat_r == expected_rd)
        else begin
            error_count++;
            $error("mismatch wb_dat_r adr %h got %h expected %h", $sampled(wb_adr),
                   $sampled(wb_dat_r), $sampled(expected_rd));
        end
    result_value: assert property (@(posedge clk) disable iff (rst)
        (read_ack && region == region_result) |-> wb_dat_r == expected_rd)
        else begin
            error_count++;
            $error("mismatch wb_dat_r result %h got %h expected %h", $sampled(index),
                   $sampled(wb_dat_r), $sampled(expected_rd));
        end
    done_value: assert property (@(posedge clk) disable iff (rst)
        (read_ack && region == region_ctrl && index == ctrl_start_addr) |->
        wb_dat_r == expected_rd)
        else begin
            error_count++;
            $error("mismatch done got %h expected %h", $sampled(wb_dat_r),
                   $sampled(expected_rd));
        end

endmodule

bind ntt_r16_top ntt_r16_assertions i_ntt_r16_assertions (.*);

// ==== sim/ntt_r16_tb.sv ====
`timescale 1ns/1ps

module ntt_r16_tb;
    import ntt_bus_pkg::*;

    localparam time period = 40ns;
    localparam int ack_limit = 8;
    localparam int poll_limit = 20;
    // rough count of bus transfers in the whole run
    localparam int bus_ops = 180;
    localparam int q = 7681;

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic wb_ack;

    int seed = 32'h9cd0_f9ac;
    int bus_errors = 0;
    int assert_errors;
    logic [wb_data_width-1:0] rd;

    ntt_r16_top i_ntt_r16_top (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = data;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ack_limit);
        if (!wb_ack) begin
            bus_errors++;
            $display("no ack for bus access at address %h", adr);
        end
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] reg_region, input int idx, input int data);
        logic [31:0] unused;
        bus_cycle(1'b1, {reg_region, idx[3:0]}, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] reg_region, input int idx);
        bus_cycle(1'b0, {reg_region, idx[3:0]}, 32'h0, rd);
    endtask

    task automatic wait_done();
        int polls;
        polls = 0;
        do begin
            wb_read(region_ctrl, ctrl_start_addr);
            polls++;
        end while (!rd[0] && polls < poll_limit);
        if (!rd[0]) begin
            bus_errors++;
            $display("done bit never came up after a launch");
        end
    endtask

    task automatic read_all(input logic [1:0] reg_region);
        for (int i = 0; i < 16; i++) begin
            wb_read(reg_region, i);
        end
    endtask

    initial begin
        #((bus_ops * 2 + 40) * period);
        $display("watchdog timeout, the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        wb_read(region_ctrl, ctrl_start_addr);
        wb_write(region_ctrl, ctrl_modulus_addr, q);
        for (int i = 0; i < 16; i++) begin
            wb_write(region_coef, i, $unsigned($random(seed)) % q);
            wb_write(region_twiddle, i, $unsigned($random(seed)) % q);
        end
        read_all(region_coef);
        read_all(region_twiddle);
        wb_read(region_ctrl, ctrl_modulus_addr);

        wb_write(region_ctrl, ctrl_start_addr, 1);
        wb_read(region_ctrl, ctrl_start_addr);
        wait_done();
        read_all(region_result);

        // relaunch with new operands without polling done in between
        wb_write(region_ctrl, ctrl_start_addr, 1);
        wb_write(region_coef, 3, $unsigned($random(seed)) % q);
        wb_write(region_twiddle, 1, $unsigned($random(seed)) % q);
        wb_write(region_twiddle, 6, $unsigned($random(seed)) % q);
        wb_write(region_ctrl, ctrl_start_addr, 1);
        wait_done();
        read_all(region_result);

        // reset in the middle of a transform
        wb_write(region_ctrl, ctrl_start_addr, 1);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        rst = 1'b0;
        wb_read(region_ctrl, ctrl_start_addr);
        read_all(region_result);
        wb_read(region_ctrl, ctrl_start_addr);

        repeat (2) @(negedge clk);
        assert_errors = i_ntt_r16_top.i_ntt_r16_assertions.error_count;
        $display("errors: assertions %0d bus %0d", assert_errors, bus_errors);
        if (assert_errors == 0 && bus_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
